// File: rsp_prep_vectors.txt
// smp_cnt chp_cnt start_addr(hex) bubble base(hex) last_addr(hex)
// Decimal counts, bubble 1 adds random idle cycles, last_addr is the final word written
16  2  10  0  00010000  17
6   2  10  0  00020000  13
13  3  40  0  00030000  4b
13  3  40  1  00030000  4b
8   4  fc  0  00050000  03
7   3  fe  1  00060000  03
1   5  80  0  00070000  84
20  1  00  1  00080000  04

// File: compile.f
rsp_pkg.sv
rsp_sample_packer.sv
rsp_beat_writer.sv
rsp_l1_ram.sv
rsp_prep_top.sv
tb_clk_gen.sv
tb_rsp_checker.sv
tb_rsp_prep.sv

// File: Bender.yml
package:
  name: rsp_prep

sources:
  # RTL, package first
  - rsp_pkg.sv
  - rsp_sample_packer.sv
  - rsp_beat_writer.sv
  - rsp_l1_ram.sv
  - rsp_prep_top.sv
  # Testbench
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_rsp_checker.sv
      - tb_rsp_prep.sv

// File: tb_rsp_prep.sv
`timescale 1ns/1ps

module tb_rsp_prep
  import rsp_pkg::*;
();

  localparam        VEC_FILE = "rsp_prep_vectors.txt";
  // Edges until the last readback has been compared
  localparam int    RD_DRAIN = 2;

  logic                     clk;
  logic                     rst_n;
  logic [SMP_CNT_WIDTH-1:0] csr_smp_cnt;
  logic [CHP_CNT_WIDTH-1:0] csr_chp_cnt;
  logic [ADDR_WIDTH-1:0]    csr_wr_start_addr;
  logic [SMP_WIDTH-1:0]     smp;
  logic                     smp_valid;
  logic [ADDR_WIDTH-1:0]    rd_addr;
  logic [BEAT_WIDTH-1:0]    rd_data;
  logic                     finish;
  // Marks a readback cycle for the checker
  logic                     rd_check;

  // Frame table, one entry per vector line
  int   v_smp[$];
  int   v_chp[$];
  int   v_start[$];
  int   v_bubble[$];
  int   v_base[$];
  int   v_last[$];
  int   total_smp;
  int   cur_frame;
  int   seed_val;
  int   check_cnt;
  int   error_cnt;
  logic vec_ready;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rsp_prep_top dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .i_csr_smp_cnt       (csr_smp_cnt),
    .i_csr_chp_cnt       (csr_chp_cnt),
    .i_csr_wr_start_addr (csr_wr_start_addr),
    .i_smp               (smp),
    .i_smp_valid         (smp_valid),
    .i_rd_addr           (rd_addr),
    .o_rd_data           (rd_data),
    .o_finish            (finish)
  );

  tb_rsp_checker u_checker (
    .clk                 (clk),
    .rst_n               (rst_n),
    .i_csr_smp_cnt       (csr_smp_cnt),
    .i_csr_chp_cnt       (csr_chp_cnt),
    .i_csr_wr_start_addr (csr_wr_start_addr),
    .i_smp               (smp),
    .i_smp_valid         (smp_valid),
    .i_rd_addr           (rd_addr),
    .i_rd_check          (rd_check),
    .i_rd_data           (rd_data),
    .i_finish            (finish),
    .o_check_cnt         (check_cnt),
    .o_error_cnt         (error_cnt)
  );

  //////////////////////
  // Vector file
  //////////////////////

  // Comment and blank lines fail the scan and are skipped
  task automatic load_vectors();
    int    fd;
    int    n;
    int    c_smp;
    int    c_chp;
    int    c_start;
    int    c_bubble;
    int    c_base;
    int    c_last;
    string line;
    total_smp = 0;
    fd = $fopen(VEC_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%d %d %h %d %h %h",
                    c_smp, c_chp, c_start, c_bubble, c_base, c_last);
        if (n == 6) begin
          v_smp.push_back(c_smp);
          v_chp.push_back(c_chp);
          v_start.push_back(c_start);
          v_bubble.push_back(c_bubble);
          v_base.push_back(c_base);
          v_last.push_back(c_last);
          total_smp += c_smp * c_chp;
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////
  // Frame driver
  //////////////////////

  task automatic run_frame(input int f);
    int n_smp;
    int n_chp;
    int start;
    int last;
    int nbeats;
    int gap;
    int addr_i;
    int err_before;
    int chk_before;
    n_smp      = v_smp[f];
    n_chp      = v_chp[f];
    start      = v_start[f];
    last       = v_last[f];
    err_before = error_cnt;
    chk_before = check_cnt;
    // Words from the start address up to the final word of the vector line
    nbeats     = ((last - start) % RAM_DEPTH + RAM_DEPTH) % RAM_DEPTH + 1;
    // CSRs one edge ahead of the first sample
    @(posedge clk);
    csr_smp_cnt       <= n_smp[SMP_CNT_WIDTH-1:0];
    csr_chp_cnt       <= n_chp[CHP_CNT_WIDTH-1:0];
    csr_wr_start_addr <= start[ADDR_WIDTH-1:0];
    for (int i = 0; i < n_smp * n_chp; i++) begin
      @(posedge clk);
      smp       <= v_base[f] + i;
      smp_valid <= 1'b1;
      // Idle cycles between samples in bubble mode
      if (v_bubble[f] != 0) begin
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge clk);
          smp_valid <= 1'b0;
        end
      end
    end
    @(posedge clk);
    smp_valid <= 1'b0;
    // Watchdog covers a finish that never comes
    do begin
      @(posedge clk);
    end while (finish !== 1'b1);
    // Sweep the words this frame wrote
    for (int a = 0; a < nbeats; a++) begin
      @(posedge clk);
      addr_i = (start + a) % RAM_DEPTH;
      rd_addr  <= addr_i[ADDR_WIDTH-1:0];
      rd_check <= 1'b1;
    end
    @(posedge clk);
    rd_check <= 1'b0;
    repeat (RD_DRAIN) @(posedge clk);
    $display("Frame %0d: %0d samples x %0d chirps at %02h, bubbles %0d: %0d checks, %0d errors",
             f, n_smp, n_chp, start, v_bubble[f],
             check_cnt - chk_before, error_cnt - err_before);
  endtask

  // Run bounded by the total sample count
  initial begin
    wait (vec_ready === 1'b1);
    repeat (total_smp * 4 + 200) @(posedge clk);
    $display("Timeout: o_finish never arrived for frame %0d", cur_frame);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    csr_smp_cnt       = '0;
    csr_chp_cnt       = '0;
    csr_wr_start_addr = '0;
    smp               = '0;
    smp_valid         = 1'b0;
    rd_addr           = '0;
    rd_check          = 1'b0;
    cur_frame         = 0;
    vec_ready         = 1'b0;
    seed_val          = $urandom(34);
    load_vectors();
    vec_ready = 1'b1;
    wait (rst_n === 1'b1);
    if (v_smp.size() == 0) begin
      $display("No frames could be read from %s", VEC_FILE);
    end else begin
      for (int f = 0; f < v_smp.size(); f++) begin
        cur_frame = f;
        run_frame(f);
      end
    end
    $display("Summary: %0d frames, %0d checks, %0d errors",
             v_smp.size(), check_cnt, error_cnt);
    if (v_smp.size() != 0 && error_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb_rsp_checker.sv
`timescale 1ns/1ps

module tb_rsp_checker
  import rsp_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [SMP_CNT_WIDTH-1:0] i_csr_smp_cnt,
  input  logic [CHP_CNT_WIDTH-1:0] i_csr_chp_cnt,
  input  logic [ADDR_WIDTH-1:0]    i_csr_wr_start_addr,
  input  logic [SMP_WIDTH-1:0]     i_smp,
  input  logic                     i_smp_valid,
  input  logic [ADDR_WIDTH-1:0]    i_rd_addr,
  input  logic                     i_rd_check,
  input  logic [BEAT_WIDTH-1:0]    i_rd_data,
  input  logic                     i_finish,
  output int                       o_check_cnt,
  output int                       o_error_cnt
);

  // Edges from last accepted sample to finish seen high
  localparam int FINISH_LAT = 5;

  // Expected L1 contents
  logic [BEAT_WIDTH-1:0]   shadow [RAM_DEPTH];
  // Lanes that some frame has written
  logic [SMP_PER_BEAT-1:0] known  [RAM_DEPTH];

  // Position of the next sample in the frame
  int                    smp_idx;
  int                    chp_idx;
  int                    beat_idx;
  int                    edge_cnt;
  // Edge of the frame's last sample
  int                    last_edge;
  logic                  frame_pending;
  // Read address issued one edge earlier
  logic                  rd_q;
  logic [ADDR_WIDTH-1:0] rd_addr_q;

  //////////////////////
  // Shadow memory
  //////////////////////

  task automatic accept_sample();
    int                    lane;
    int                    addr_i;
    logic [ADDR_WIDTH-1:0] addr;
    lane   = smp_idx % SMP_PER_BEAT;
    // Word address wraps at the end of L1
    addr_i = (int'(i_csr_wr_start_addr) + beat_idx) % RAM_DEPTH;
    addr   = addr_i[ADDR_WIDTH-1:0];
    shadow[addr][lane*SMP_WIDTH +: SMP_WIDTH] = i_smp;
    known[addr][lane] = 1'b1;
    if (smp_idx == int'(i_csr_smp_cnt) - 1) begin
      // Chirp end closes the beat, full or not
      smp_idx = 0;
      beat_idx++;
      chp_idx++;
      if (chp_idx == int'(i_csr_chp_cnt)) begin
        frame_pending = 1'b1;
        last_edge     = edge_cnt;
        chp_idx       = 0;
        beat_idx      = 0;
      end
    end else begin
      smp_idx++;
      if (lane == SMP_PER_BEAT - 1) begin
        beat_idx++;
      end
    end
  endtask

  //////////////////////
  // Comparisons
  //////////////////////

  // Only lanes written at least once are compared
  task automatic compare_word(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [BEAT_WIDTH-1:0] data);
    logic [SMP_WIDTH-1:0] got;
    logic [SMP_WIDTH-1:0] exp;
    for (int l = 0; l < SMP_PER_BEAT; l++) begin
      if (known[addr][l]) begin
        got = data[l*SMP_WIDTH +: SMP_WIDTH];
        exp = shadow[addr][l*SMP_WIDTH +: SMP_WIDTH];
        o_check_cnt++;
        if (got !== exp) begin
          o_error_cnt++;
          $display("CHECK FAILED at %0t ns: word %02h lane %0d read %08h, expected %08h",
                   $time, addr, l, got, exp);
        end
      end
    end
  endtask

  task automatic check_finish();
    o_check_cnt++;
    if (!frame_pending) begin
      o_error_cnt++;
      $display("CHECK FAILED at %0t ns: o_finish high with no completed frame", $time);
    end else begin
      if (edge_cnt - last_edge != FINISH_LAT) begin
        o_error_cnt++;
        $display("CHECK FAILED at %0t ns: o_finish %0d cycles after last sample, expected %0d",
                 $time, edge_cnt - last_edge, FINISH_LAT);
      end
      frame_pending = 1'b0;
    end
  endtask

  // All inputs sampled as they stood before the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      smp_idx       = 0;
      chp_idx       = 0;
      beat_idx      = 0;
      edge_cnt      = 0;
      last_edge     = 0;
      frame_pending = 1'b0;
      rd_q          = 1'b0;
      rd_addr_q     = '0;
      o_check_cnt   = 0;
      o_error_cnt   = 0;
      for (int w = 0; w < RAM_DEPTH; w++) begin
        known[w] = '0;
      end
    end else begin
      edge_cnt++;
      // Registered read data belongs to the previous address
      if (rd_q) begin
        compare_word(rd_addr_q, i_rd_data);
      end
      if (i_finish) begin
        check_finish();
      end
      if (i_smp_valid) begin
        accept_sample();
      end
      rd_q      = i_rd_check;
      rd_addr_q = i_rd_addr;
    end
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // Half of the 100 ns period
  localparam int CLK_HALF   = 50;
  localparam int RST_CYCLES = 8;

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Reset low for the first cycles, released on an edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: rsp_prep_top.sv
`timescale 1ns/1ps

module rsp_prep_top
  import rsp_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [SMP_CNT_WIDTH-1:0] i_csr_smp_cnt,
  input  logic [CHP_CNT_WIDTH-1:0] i_csr_chp_cnt,
  input  logic [ADDR_WIDTH-1:0]    i_csr_wr_start_addr,
  input  logic [SMP_WIDTH-1:0]     i_smp,
  input  logic                     i_smp_valid,
  input  logic [ADDR_WIDTH-1:0]    i_rd_addr,
  output logic [BEAT_WIDTH-1:0]    o_rd_data,
  output logic                     o_finish
);

  // Packer to writer
  logic [BEAT_WIDTH-1:0] beat_data;
  logic [STRB_WIDTH-1:0] beat_strb;
  logic                  beat_valid;
  logic                  beat_last;

  // Writer to RAM
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [BEAT_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  //////////////////////
  // Sample packing
  //////////////////////

  rsp_sample_packer u_packer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_csr_smp_cnt (i_csr_smp_cnt),
    .i_smp         (i_smp),
    .i_smp_valid   (i_smp_valid),
    .o_beat_data   (beat_data),
    .o_beat_strb   (beat_strb),
    .o_beat_valid  (beat_valid),
    .o_beat_last   (beat_last)
  );

  //////////////////////
  // Address and finish
  //////////////////////

  rsp_beat_writer u_writer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .i_csr_chp_cnt       (i_csr_chp_cnt),
    .i_csr_wr_start_addr (i_csr_wr_start_addr),
    .i_beat_data         (beat_data),
    .i_beat_strb         (beat_strb),
    .i_beat_valid        (beat_valid),
    .i_beat_last         (beat_last),
    .o_wr_en             (wr_en),
    .o_wr_addr           (wr_addr),
    .o_wr_data           (wr_data),
    .o_wr_strb           (wr_strb),
    .o_finish            (o_finish)
  );

  //////////////////////
  // L1 storage
  //////////////////////

  rsp_l1_ram u_ram (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .i_rd_addr (i_rd_addr),
    .o_rd_data (o_rd_data)
  );

endmodule

// File: rsp_l1_ram.sv
`timescale 1ns/1ps

module rsp_l1_ram
  import rsp_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_wr_en,
  input  logic [ADDR_WIDTH-1:0] i_wr_addr,
  input  logic [BEAT_WIDTH-1:0] i_wr_data,
  input  logic [STRB_WIDTH-1:0] i_wr_strb,
  input  logic [ADDR_WIDTH-1:0] i_rd_addr,
  output logic [BEAT_WIDTH-1:0] o_rd_data
);

  // One beat per word
  logic [BEAT_WIDTH-1:0] mem [RAM_DEPTH];

  //////////////////////
  // Write port
  //////////////////////

  // Byte lanes under strobe
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wr_strb[b]) begin
          mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////
  // Read port
  //////////////////////

  // Registered, same-address collision returns old word
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

  // Writer address must be resolved on every write
  a_wr_addr_known : assert property (
    @(posedge clk) i_wr_en |-> !$isunknown(i_wr_addr)
  );

endmodule

// File: rsp_beat_writer.sv
`timescale 1ns/1ps

module rsp_beat_writer
  import rsp_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [CHP_CNT_WIDTH-1:0] i_csr_chp_cnt,
  input  logic [ADDR_WIDTH-1:0]    i_csr_wr_start_addr,
  input  logic [BEAT_WIDTH-1:0]    i_beat_data,
  input  logic [STRB_WIDTH-1:0]    i_beat_strb,
  input  logic                     i_beat_valid,
  input  logic                     i_beat_last,
  output logic                     o_wr_en,
  output logic [ADDR_WIDTH-1:0]    o_wr_addr,
  output logic [BEAT_WIDTH-1:0]    o_wr_data,
  output logic [STRB_WIDTH-1:0]    o_wr_strb,
  output logic                     o_finish
);

  // Delay line, index 0 is the first stage
  logic [BEAT_WIDTH-1:0]    dly_data  [WR_DELAY];
  logic [STRB_WIDTH-1:0]    dly_strb  [WR_DELAY];
  logic                     dly_valid [WR_DELAY];
  logic                     dly_last  [WR_DELAY];

  // Beats written in this frame
  logic [ADDR_WIDTH-1:0]    beat_cnt;
  // Chirps finished in this frame
  logic [CHP_CNT_WIDTH-1:0] chp_cnt;
  logic [ADDR_WIDTH-1:0]    cur_addr;
  logic                     tail_valid;
  logic                     tail_last;
  logic                     frame_final;
  // Final write of the frame sits in the output register
  logic                     wr_final;

  //////////////////////
  // Delay stages
  //////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < WR_DELAY; i++) begin
        dly_valid[i] <= 1'b0;
        dly_last[i]  <= 1'b0;
      end
    end else begin
      dly_valid[0] <= i_beat_valid;
      dly_last[0]  <= i_beat_valid && i_beat_last;
      for (int i = 1; i < WR_DELAY; i++) begin
        dly_valid[i] <= dly_valid[i-1];
        dly_last[i]  <= dly_last[i-1];
      end
    end
  end

  // Payload shift
  always_ff @(posedge clk) begin
    dly_data[0] <= i_beat_data;
    dly_strb[0] <= i_beat_strb;
    for (int i = 1; i < WR_DELAY; i++) begin
      dly_data[i] <= dly_data[i-1];
      dly_strb[i] <= dly_strb[i-1];
    end
  end

  assign tail_valid  = dly_valid[WR_DELAY-1];
  assign tail_last   = dly_last[WR_DELAY-1];
  // Last beat of the last chirp
  assign frame_final = tail_valid && tail_last && (chp_cnt == i_csr_chp_cnt - 1'b1);
  // Wraps modulo RAM_DEPTH by width
  assign cur_addr    = i_csr_wr_start_addr + beat_cnt;

  //////////////////////
  // Beat and chirp count
  //////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      chp_cnt  <= '0;
    end else if (tail_valid) begin
      beat_cnt <= frame_final ? '0 : beat_cnt + 1'b1;
      if (frame_final) begin
        chp_cnt <= '0;
      end else if (tail_last) begin
        chp_cnt <= chp_cnt + 1'b1;
      end
    end
  end

  //////////////////////
  // Output register
  //////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_en   <= 1'b0;
      o_wr_addr <= '0;
      wr_final  <= 1'b0;
      o_finish  <= 1'b0;
    end else begin
      o_wr_en  <= tail_valid;
      wr_final <= frame_final;
      // One cycle after the final write
      o_finish <= wr_final;
      if (tail_valid) begin
        o_wr_addr <= cur_addr;
      end else if (wr_final) begin
        // Back to start once the frame is written
        o_wr_addr <= i_csr_wr_start_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    o_wr_data <= dly_data[WR_DELAY-1];
    o_wr_strb <= dly_strb[WR_DELAY-1];
  end

  // Every write carries at least one byte
  a_wr_strb_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n) o_wr_en |-> (o_wr_strb != '0)
  );

  // Next frame must not start before finish
  a_finish_alone : assert property (
    @(posedge clk) disable iff (!rst_n) !(o_finish && o_wr_en)
  );

endmodule

// File: rsp_sample_packer.sv
`timescale 1ns/1ps

module rsp_sample_packer
  import rsp_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [SMP_CNT_WIDTH-1:0] i_csr_smp_cnt,
  input  logic [SMP_WIDTH-1:0]     i_smp,
  input  logic                     i_smp_valid,
  output logic [BEAT_WIDTH-1:0]    o_beat_data,
  output logic [STRB_WIDTH-1:0]    o_beat_strb,
  output logic                     o_beat_valid,
  output logic                     o_beat_last
);

  // Lane for the next sample
  logic [LANE_WIDTH-1:0]    lane_cnt;
  // Sample index within the chirp
  logic [SMP_CNT_WIDTH-1:0] smp_cnt;
  // Lanes collected so far
  logic [BEAT_WIDTH-1:0]    acc_data;
  logic [BEAT_WIDTH-1:0]    beat_nxt;
  logic [STRB_WIDTH-1:0]    strb_nxt;
  logic                     chirp_end;
  logic                     beat_done;

  //////////////////////
  // Lane merge
  //////////////////////

  // Last sample of the chirp
  assign chirp_end = (smp_cnt == i_csr_smp_cnt - 1'b1);
  // Beat closes on a full set of lanes or at chirp end
  assign beat_done = chirp_end || (lane_cnt == SMP_PER_BEAT - 1);

  always_comb begin
    beat_nxt = acc_data;
    // Sample 0 in the low lane
    beat_nxt[lane_cnt*SMP_WIDTH +: SMP_WIDTH] = i_smp;
    // Enable bytes of lanes up to the current one
    for (int k = 0; k < SMP_PER_BEAT; k++) begin
      strb_nxt[k*SMP_BYTES +: SMP_BYTES] = (k <= lane_cnt) ? '1 : '0;
    end
  end

  //////////////////////
  // Counters
  //////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
      smp_cnt  <= '0;
    end else if (i_smp_valid) begin
      lane_cnt <= beat_done ? '0 : lane_cnt + 1'b1;
      // Restart count at every chirp end
      smp_cnt  <= chirp_end ? '0 : smp_cnt + 1'b1;
    end
  end

  // Lane accumulator
  always_ff @(posedge clk) begin
    if (i_smp_valid) begin
      acc_data <= beat_nxt;
    end
  end

  //////////////////////
  // Beat output
  //////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_beat_valid <= 1'b0;
      o_beat_last  <= 1'b0;
    end else begin
      // Single-cycle pulses
      o_beat_valid <= i_smp_valid && beat_done;
      o_beat_last  <= i_smp_valid && chirp_end;
    end
  end

  always_ff @(posedge clk) begin
    if (i_smp_valid && beat_done) begin
      o_beat_data <= beat_nxt;
      o_beat_strb <= strb_nxt;
    end
  end

  // Sample index stays inside the programmed chirp length
  a_smp_in_chirp : assert property (
    @(posedge clk) disable iff (!rst_n) i_smp_valid |-> (smp_cnt < i_csr_smp_cnt)
  );

endmodule

// File: rsp_pkg.sv
package rsp_pkg;

  //////////////////////
  // Sample and beat
  //////////////////////

  // One complex sample, I and Q packed
  localparam int SMP_WIDTH     = 32;
  // Samples packed into one memory beat
  localparam int SMP_PER_BEAT  = 4;
  localparam int BEAT_WIDTH    = SMP_WIDTH * SMP_PER_BEAT;
  // One strobe bit per byte of a beat
  localparam int STRB_WIDTH    = BEAT_WIDTH / 8;
  // Bytes covered by one sample lane
  localparam int SMP_BYTES     = SMP_WIDTH / 8;
  // Lane index inside a beat
  localparam int LANE_WIDTH    = $clog2(SMP_PER_BEAT);

  //////////////////////
  // CSR widths
  //////////////////////

  // Samples per chirp
  localparam int SMP_CNT_WIDTH = 12;
  // Chirps per frame
  localparam int CHP_CNT_WIDTH = 8;

  //////////////////////
  // L1 memory
  //////////////////////

  // Word count, one beat per word
  localparam int RAM_DEPTH     = 256;
  localparam int ADDR_WIDTH    = $clog2(RAM_DEPTH);

  // Delay stages in the beat writer, output register not included
  localparam int WR_DELAY      = 2;

endpackage
